/* hw/periph_params.svh */
////////////////////////////////////////////////////////////////////////////
// peripheral map constants for the data-bus subsystem.
// region bases, register offsets and gpio width.
////////////////////////////////////////////////////////////////////////////

`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// region bases. each region spans 256 bytes.
`define PERIPH_GPIO_BASE   32'hF020_0000
`define PERIPH_TIMER_BASE  32'hF060_0000
`define PERIPH_REGION_BITS 8 // decode looks above this bit.

// gpio register offsets.
`define REG_GPIO_DIR 8'h00 // direction, 1 drives the pin.
`define REG_GPIO_A   8'h04 // pins 7..0.
`define REG_GPIO_B   8'h08 // pins 15..8.

// timer register offsets.
`define REG_TMR_COUNT   8'h00
`define REG_TMR_COMPARE 8'h04
`define REG_TMR_CTRL    8'h08 // bit 0 enable, bit 1 flag.

`define GPIO_PINS 16

`endif

/* hw/periph_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the peripheral bus.
// device select and in-region register offset.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

package periph_pkg;

	// which device owns the current access.
	// DEV_NONE also covers an idle bus.
	typedef enum logic [1:0] {
		DEV_NONE  = 2'd0, // unmapped or de low.
		DEV_GPIO  = 2'd1,
		DEV_TIMER = 2'd2
	} dev_sel_t;

	// byte offset inside a 256 byte region.
	// word registers sit on multiples of four.
	typedef logic [`PERIPH_REGION_BITS-1:0] reg_off_t;

	// decode fills this from the low address bits.
	// gpio and timer compare it against the REG_* offsets.
	// read_return only needs the select.

endpackage

/* hw/bus_decode.sv */
////////////////////////////////////////////////////////////////////////////
// data bus decode stage.
// maps daddr onto a device select, a register offset and
// per-device write strobes.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module bus_decode (
	input  logic                  de,
	input  logic                  drw,
	input  logic [31:0]           daddr,
	output periph_pkg::dev_sel_t  sel,
	output periph_pkg::reg_off_t  off,
	output logic                  gpio_we,
	output logic                  timer_we
);
	import periph_pkg::*;

	// bases held as vectors so the upper bits can be sliced.
	localparam logic [31:0] GPIO_BASE  = `PERIPH_GPIO_BASE;
	localparam logic [31:0] TIMER_BASE = `PERIPH_TIMER_BASE;

	logic gpio_hit;
	logic timer_hit;
	logic wr;

	// region match on the bits above the offset.
	assign gpio_hit  = (daddr[31:`PERIPH_REGION_BITS] == GPIO_BASE[31:`PERIPH_REGION_BITS]);
	assign timer_hit = (daddr[31:`PERIPH_REGION_BITS] == TIMER_BASE[31:`PERIPH_REGION_BITS]);

	assign wr = de & drw; // write cycle.

	// offset goes through untouched.
	assign off = daddr[`PERIPH_REGION_BITS-1:0];

	always_comb begin
		sel = DEV_NONE; // idle or unmapped.
		if (de) begin
			if (gpio_hit)
				sel = DEV_GPIO;
			else if (timer_hit)
				sel = DEV_TIMER;
		end
	end

	// one strobe at most, only for the addressed block.
	assign gpio_we  = wr & gpio_hit;
	assign timer_we = wr & timer_hit;

endmodule

/* hw/mod_gpio.sv */
////////////////////////////////////////////////////////////////////////////
// 16 pin gpio block.
// direction register plus two 8-bit output blocks, pad-level
// readback, split in/out/oe pins.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module mod_gpio (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       we,
	input  periph_pkg::reg_off_t       off,
	input  logic [31:0]                wdata,
	output logic [31:0]                rdata,
	input  logic [`GPIO_PINS-1:0]      gpio_in,
	output logic [`GPIO_PINS-1:0]      gpio_out,
	output logic [`GPIO_PINS-1:0]      gpio_oe
);
	localparam int BLK_W = `GPIO_PINS / 2; // pins per block.

	logic [`GPIO_PINS-1:0] direction; // 1 = output.
	logic [BLK_W-1:0]      gpio_a;    // pins 7..0.
	logic [BLK_W-1:0]      gpio_b;    // pins 15..8.
	logic [`GPIO_PINS-1:0] blk_val;   // both blocks, pin order.
	logic [`GPIO_PINS-1:0] pin_lvl;   // what the pad shows.

	// register writes, taken at the rising edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			direction <= '0; // all pins input.
			gpio_a    <= '0;
			gpio_b    <= '0;
		end else if (we) begin
			case (off)
				`REG_GPIO_DIR: direction <= wdata[`GPIO_PINS-1:0];
				`REG_GPIO_A:   gpio_a    <= wdata[BLK_W-1:0];
				`REG_GPIO_B:   gpio_b    <= wdata[BLK_W-1:0];
				default: ; // other offsets ignored.
			endcase
		end
	end

	assign blk_val = {gpio_b, gpio_a};

	// pin drive.
	// undriven pins show zero on gpio_out, oe says who drives.
	assign gpio_oe  = direction;
	assign gpio_out = blk_val & direction;

	// driven pins read back our own value, inputs read the pad.
	assign pin_lvl = (blk_val & direction) | (gpio_in & ~direction);

	// read mux, combinational like the rest of the bus.
	always_comb begin
		case (off)
			`REG_GPIO_DIR:
				rdata = {{(32-`GPIO_PINS){1'b0}}, direction};
			`REG_GPIO_A:
				rdata = {{(32-BLK_W){1'b0}}, pin_lvl[BLK_W-1:0]}; // block a.
			`REG_GPIO_B:
				rdata = {{(32-BLK_W){1'b0}}, pin_lvl[`GPIO_PINS-1:BLK_W]}; // block b.
			default:
				rdata = 32'h0000_0000;
		endcase
	end

	// note that a block write while the pin is an input is kept.
	// it shows up on the pin once direction flips to output.

endmodule

/* hw/mod_timer.sv */
////////////////////////////////////////////////////////////////////////////
// interval timer.
// free-running count with compare, enable, sticky match flag
// and an interrupt level that follows the flag.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module mod_timer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  periph_pkg::reg_off_t  off,
	input  logic [31:0]           wdata,
	output logic [31:0]           rdata,
	output logic                  irq
);
	logic [31:0] count;
	logic [31:0] compare;
	logic        enable;  // ctrl bit 0.
	logic        flag;    // ctrl bit 1, sticky.
	logic        match;
	logic        wr_count;
	logic        wr_compare;
	logic        wr_ctrl;

	// per-register write strobes.
	assign wr_count   = we && (off == `REG_TMR_COUNT);
	assign wr_compare = we && (off == `REG_TMR_COMPARE);
	assign wr_ctrl    = we && (off == `REG_TMR_CTRL);

	assign match = enable && (count == compare); // only counts while enabled.

	always_ff @(posedge clk) begin
		if (rst) begin
			count   <= '0;
			compare <= '1; // far away until software sets it.
			enable  <= 1'b0;
			flag    <= 1'b0;
		end else begin
			// count. a bus load beats increment and wrap.
			if (wr_count)
				count <= wdata;
			else if (match)
				count <= '0; // wrap on match.
			else if (enable)
				count <= count + 32'd1;

			if (wr_compare)
				compare <= wdata;

			if (wr_ctrl)
				enable <= wdata[0];

			// a new match wins over a clear in the same cycle.
			if (match)
				flag <= 1'b1;
			else if (wr_ctrl && wdata[1])
				flag <= 1'b0; // write 1 to clear.
		end
	end

	assign irq = flag; // level, held until cleared.

	always_comb begin
		case (off)
			`REG_TMR_COUNT:   rdata = count;
			`REG_TMR_COMPARE: rdata = compare;
			`REG_TMR_CTRL:    rdata = {30'd0, flag, enable};
			default:          rdata = 32'h0000_0000;
		endcase
	end

endmodule

/* hw/read_return.sv */
////////////////////////////////////////////////////////////////////////////
// result stage of the data bus.
// picks the read word of the addressed device, zero otherwise.
////////////////////////////////////////////////////////////////////////////

module read_return (
	input  periph_pkg::dev_sel_t  sel,
	input  logic [31:0]           gpio_rdata,
	input  logic [31:0]           timer_rdata,
	output logic [31:0]           dout
);
	import periph_pkg::*;

	// new devices add a select value and a case arm here.
	always_comb begin
		case (sel)
			DEV_GPIO:
				dout = gpio_rdata;
			DEV_TIMER:
				dout = timer_rdata;
			default:
				dout = 32'h0000_0000; // idle bus or unmapped address.
		endcase
	end

	// no register here.
	// dout is valid in the same cycle as de and daddr.

endmodule

/* hw/periph_top.sv */
////////////////////////////////////////////////////////////////////////////
// peripheral subsystem top.
// decode, gpio, timer and read return on one data port.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module periph_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   de,      // access enable, one cycle.
	input  logic                   drw,     // 1 = write.
	input  logic [31:0]            daddr,
	input  logic [31:0]            din,
	output logic [31:0]            dout,
	input  logic [`GPIO_PINS-1:0]  gpio_in,
	output logic [`GPIO_PINS-1:0]  gpio_out,
	output logic [`GPIO_PINS-1:0]  gpio_oe,
	output logic                   irq
);
	import periph_pkg::*;

	dev_sel_t    sel;
	reg_off_t    off;
	logic        gpio_we;
	logic        timer_we;
	logic [31:0] gpio_rdata;
	logic [31:0] timer_rdata;

	bus_decode u_decode (
		.de       (de),
		.drw      (drw),
		.daddr    (daddr),
		.sel      (sel),
		.off      (off),
		.gpio_we  (gpio_we),
		.timer_we (timer_we)
	);

	mod_gpio u_gpio (
		.clk      (clk),
		.rst      (rst),
		.we       (gpio_we),
		.off      (off),
		.wdata    (din),
		.rdata    (gpio_rdata),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

	mod_timer u_timer (
		.clk   (clk),
		.rst   (rst),
		.we    (timer_we),
		.off   (off),
		.wdata (din),
		.rdata (timer_rdata),
		.irq   (irq)
	);

	read_return u_return (
		.sel         (sel),
		.gpio_rdata  (gpio_rdata),
		.timer_rdata (timer_rdata),
		.dout        (dout)
	);

endmodule

/* sim/periph_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// bound checker for the peripheral subsystem.
// keeps its own copy of every register from the bus traffic and
// compares pins, irq and read data against it each cycle.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module periph_assertions (
	input logic                  clk,
	input logic                  rst,
	input logic                  de,
	input logic                  drw,
	input logic [31:0]           daddr,
	input logic [31:0]           din,
	input logic [31:0]           dout,
	input logic [`GPIO_PINS-1:0] gpio_in,
	input logic [`GPIO_PINS-1:0] gpio_out,
	input logic [`GPIO_PINS-1:0] gpio_oe,
	input logic                  irq
);
	localparam logic [31:0] GPIO_BASE  = `PERIPH_GPIO_BASE;
	localparam logic [31:0] TIMER_BASE = `PERIPH_TIMER_BASE;

	logic [15:0] dir_sh;   // shadow direction.
	logic [7:0]  a_sh;     // shadow block a.
	logic [7:0]  b_sh;
	logic [31:0] count_sh;
	logic [31:0] cmp_sh;
	logic        en_sh;
	logic        flag_sh;
	logic        rst_q;    // rst one cycle back, for the release edge.
	logic        hit_gpio;
	logic        hit_timer;
	logic        wr_t;
	logic [7:0]  off;
	logic        match;
	logic [15:0] pins;     // pad level as software should see it.
	logic [31:0] exp_rd;
	logic        ok_rst;
	logic        ok_oe;
	logic        ok_out;
	logic        ok_irq;
	logic        ok_rd;
	logic        ok_idle;
	int          fail_count = 0; // read by the testbench.

	assign hit_gpio  = de && (daddr[31:`PERIPH_REGION_BITS] == GPIO_BASE[31:`PERIPH_REGION_BITS]);
	assign hit_timer = de && (daddr[31:`PERIPH_REGION_BITS] == TIMER_BASE[31:`PERIPH_REGION_BITS]);
	assign wr_t  = hit_timer && drw;
	assign off   = daddr[`PERIPH_REGION_BITS-1:0];
	assign match = en_sh && (count_sh == cmp_sh);
	assign pins  = ({b_sh, a_sh} & dir_sh) | (gpio_in & ~dir_sh);

	always_ff @(posedge clk) begin
		rst_q <= rst;
		if (rst) begin
			dir_sh   <= '0;
			a_sh     <= '0;
			b_sh     <= '0;
			count_sh <= '0;
			cmp_sh   <= '1;
			en_sh    <= 1'b0;
			flag_sh  <= 1'b0;
		end else begin
			if (hit_gpio && drw) begin
				case (off)
					`REG_GPIO_DIR: dir_sh <= din[15:0];
					`REG_GPIO_A:   a_sh   <= din[7:0];
					`REG_GPIO_B:   b_sh   <= din[7:0];
					default: ;
				endcase
			end
			if (wr_t && off == `REG_TMR_COUNT)
				count_sh <= din; // load beats wrap.
			else if (match)
				count_sh <= '0;
			else if (en_sh)
				count_sh <= count_sh + 32'd1;
			if (wr_t && off == `REG_TMR_COMPARE)
				cmp_sh <= din;
			if (wr_t && off == `REG_TMR_CTRL)
				en_sh <= din[0];
			if (match)
				flag_sh <= 1'b1; // match beats clear.
			else if (wr_t && off == `REG_TMR_CTRL && din[1])
				flag_sh <= 1'b0;
		end
	end

	// expected read word.
	always_comb begin
		exp_rd = 32'h0000_0000;
		if (hit_gpio) begin
			case (off)
				`REG_GPIO_DIR: exp_rd = {16'd0, dir_sh};
				`REG_GPIO_A:   exp_rd = {24'd0, pins[7:0]};
				`REG_GPIO_B:   exp_rd = {24'd0, pins[15:8]};
				default: ;
			endcase
		end else if (hit_timer) begin
			case (off)
				`REG_TMR_COUNT:   exp_rd = count_sh;
				`REG_TMR_COMPARE: exp_rd = cmp_sh;
				`REG_TMR_CTRL:    exp_rd = {30'd0, flag_sh, en_sh};
				default: ;
			endcase
		end
	end

	assign ok_rst  = !(rst_q && !rst) || (gpio_oe == '0 && gpio_out == '0 && !irq);
	assign ok_oe   = (gpio_oe == dir_sh);
	assign ok_out  = (gpio_out == ({b_sh, a_sh} & dir_sh));
	assign ok_irq  = (irq == flag_sh);
	assign ok_rd   = !(de && !drw) || (dout == exp_rd);
	assign ok_idle = de || (dout == 32'h0000_0000);

	// one tally of failing cycles, same sampling as the assertions.
	always_ff @(posedge clk) begin
		if (!ok_rst || (!rst && !(ok_oe && ok_out && ok_irq && ok_rd && ok_idle)))
			fail_count <= fail_count + 1;
	end

	a_rst: assert property (@(posedge clk) ok_rst)
		else $error("outputs not cleared in the cycle after reset release");
	a_oe: assert property (@(posedge clk) disable iff (rst) ok_oe)
		else $error("[ERROR] gpio_oe %h, expected %h", $sampled(gpio_oe), $sampled(dir_sh));
	a_out: assert property (@(posedge clk) disable iff (rst) ok_out)
		else $error("[ERROR] gpio_out %h, expected %h", $sampled(gpio_out),
			$sampled({b_sh, a_sh} & dir_sh));
	a_irq: assert property (@(posedge clk) disable iff (rst) ok_irq)
		else $error("[ERROR] irq %h, expected %h", $sampled(irq), $sampled(flag_sh));
	a_rd: assert property (@(posedge clk) disable iff (rst) ok_rd)
		else $error("[ERROR] dout %h, expected %h", $sampled(dout), $sampled(exp_rd));
	a_idle: assert property (@(posedge clk) disable iff (rst) ok_idle)
		else $error("[ERROR] dout %h with de low, expected 00000000", $sampled(dout));

endmodule

bind periph_top periph_assertions u_chk (
	.clk      (clk),
	.rst      (rst),
	.de       (de),
	.drw      (drw),
	.daddr    (daddr),
	.din      (din),
	.dout     (dout),
	.gpio_in  (gpio_in),
	.gpio_out (gpio_out),
	.gpio_oe  (gpio_oe),
	.irq      (irq)
);

/* sim/tb_periph.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the peripheral subsystem.
// runs six tests over the data port and models the gpio pads.
////////////////////////////////////////////////////////////////////////////

`include "periph_params.svh"

module tb_periph;
	localparam logic [31:0] GPIO = `PERIPH_GPIO_BASE;
	localparam logic [31:0] TMR  = `PERIPH_TIMER_BASE;

	logic        clk;
	logic        rst;
	logic        de;
	logic        drw;
	logic [31:0] daddr;
	logic [31:0] din;
	logic [31:0] dout;
	logic [15:0] gpio_in;
	logic [15:0] gpio_out;
	logic [15:0] gpio_oe;
	logic        irq;
	logic [15:0] pad_rand;   // level on undriven pins.
	logic [31:0] rnd;
	logic [15:0] dir;
	logic [7:0]  blk_a;
	logic [7:0]  blk_b;
	integer      seed;
	int          errors;     // tb errors in the running test.
	int          chk_base;   // checker tally at test start.
	int          tests_run;
	int          tests_failed;
	int          total_fail;

	periph_top dut (
		.clk (clk), .rst (rst), .de (de), .drw (drw), .daddr (daddr), .din (din),
		.dout (dout), .gpio_in (gpio_in), .gpio_out (gpio_out), .gpio_oe (gpio_oe),
		.irq (irq)
	);

	// pad. driven pins show our own value, the rest float to a random level.
	assign gpio_in = (gpio_out & gpio_oe) | (pad_rand & ~gpio_oe);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [7:0] off);
		return base | {24'd0, off};
	endfunction

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		de    <= 1'b1;
		drw   <= 1'b1;
		daddr <= addr;
		din   <= data;
		@(posedge clk); // write lands here.
		de  <= 1'b0;
		drw <= 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		de    <= 1'b1;
		drw   <= 1'b0;
		daddr <= addr;
		@(negedge clk);
		data = dout; // mid-cycle, stable.
		@(posedge clk);
		de <= 1'b0;
	endtask

	task automatic check_sig(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_read(input string name, input logic [31:0] addr,
			input logic [31:0] exp);
		logic [31:0] got;
		bus_read(addr, got);
		check_sig(name, got, exp);
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		@(negedge clk); // look at irq mid-cycle only.
		while (!irq && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			$display("irq did not rise within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int fails;
		@(negedge clk); // let the checker tally settle.
		fails = errors + (dut.u_chk.fail_count - chk_base);
		tests_run++;
		if (fails != 0)
			tests_failed++;
		total_fail += fails;
		$display("test %0d %-16s %s", tests_run, name, (fails == 0) ? "ok" : "failed");
		errors   = 0;
		chk_base = dut.u_chk.fail_count;
	endtask

	initial begin
		rst = 1'b1;
		de = 1'b0;
		drw = 1'b0;
		daddr = '0;
		din = '0;
		pad_rand = '0;
		seed = 32'h5391;
		errors = 0;
		chk_base = 0;
		tests_run = 0;
		tests_failed = 0;
		total_fail = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// 1. reset state.
		@(negedge clk);
		check_sig("gpio_oe", {16'd0, gpio_oe}, 32'h0);
		check_sig("irq", {31'd0, irq}, 32'h0);
		expect_read("gpio dir", reg_addr(GPIO, `REG_GPIO_DIR), 32'h0);
		expect_read("timer count", reg_addr(TMR, `REG_TMR_COUNT), 32'h0);
		end_test("reset state");

		// 2. direction and output blocks.
		bus_write(reg_addr(GPIO, `REG_GPIO_DIR), 32'h0000_F00F);
		bus_write(reg_addr(GPIO, `REG_GPIO_A), 32'h0000_00A5);
		bus_write(reg_addr(GPIO, `REG_GPIO_B), 32'h0000_003C);
		@(negedge clk);
		check_sig("gpio_oe", {16'd0, gpio_oe}, 32'h0000_F00F);
		check_sig("gpio_out", {16'd0, gpio_out}, 32'h0000_3005);
		bus_write(reg_addr(GPIO, `REG_GPIO_DIR), 32'h0000_FFFF);
		bus_write(reg_addr(GPIO, `REG_GPIO_A), 32'h0000_00FF);
		@(negedge clk);
		check_sig("gpio_out", {16'd0, gpio_out}, 32'h0000_3CFF);
		end_test("dir and output");

		// 3. pin readback, random directions and pad levels.
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			dir = rnd[15:0];
			rnd = $random(seed);
			blk_a = rnd[7:0];
			blk_b = rnd[15:8];
			bus_write(reg_addr(GPIO, `REG_GPIO_DIR), {16'd0, dir});
			bus_write(reg_addr(GPIO, `REG_GPIO_A), {24'd0, blk_a});
			bus_write(reg_addr(GPIO, `REG_GPIO_B), {24'd0, blk_b});
			rnd = $random(seed);
			@(posedge clk);
			pad_rand <= rnd[15:0];
			expect_read("pins a", reg_addr(GPIO, `REG_GPIO_A),
				{24'd0, (blk_a & dir[7:0]) | (rnd[7:0] & ~dir[7:0])});
			expect_read("pins b", reg_addr(GPIO, `REG_GPIO_B),
				{24'd0, (blk_b & dir[15:8]) | (rnd[15:8] & ~dir[15:8])});
		end
		end_test("pin readback");

		// 4. timer match, flag and clear.
		bus_write(reg_addr(TMR, `REG_TMR_COMPARE), 32'd5);
		bus_write(reg_addr(TMR, `REG_TMR_COUNT), 32'd0);
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h1);
		wait_irq(40);
		bus_read(reg_addr(TMR, `REG_TMR_COUNT), rnd);
		bus_read(reg_addr(TMR, `REG_TMR_CTRL), rnd); // flag and enable both up.
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h3); // clear, keep running.
		wait_irq(40);
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h2); // stop and clear.
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h2);
		@(negedge clk);
		check_sig("irq", {31'd0, irq}, 32'h0);
		end_test("timer match");

		// 5. idle and unmapped accesses.
		@(posedge clk);
		de    <= 1'b0;
		drw   <= 1'b1; // write strobe without de.
		daddr <= reg_addr(TMR, `REG_TMR_COMPARE);
		din   <= 32'hDEAD_BEEF;
		@(negedge clk);
		check_sig("dout", dout, 32'h0);
		@(posedge clk);
		drw <= 1'b0;
		expect_read("unmapped", 32'hF040_0004, 32'h0);
		expect_read("low address", 32'h0000_0010, 32'h0);
		bus_write(32'hF040_0004, 32'hFFFF_FFFF);
		bus_write(reg_addr(GPIO, 8'h0C), 32'hFFFF_FFFF);
		expect_read("timer compare", reg_addr(TMR, `REG_TMR_COMPARE), 32'd5);
		expect_read("gpio spare", reg_addr(GPIO, 8'h0C), 32'h0);
		bus_read(reg_addr(GPIO, `REG_GPIO_DIR), rnd);
		end_test("unmapped and idle");

		// 6. count load while running.
		bus_write(reg_addr(TMR, `REG_TMR_COMPARE), 32'hFFFF_0000);
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h1);
		bus_write(reg_addr(TMR, `REG_TMR_COUNT), 32'h1234_5678);
		expect_read("timer count", reg_addr(TMR, `REG_TMR_COUNT), 32'h1234_5679);
		bus_write(reg_addr(TMR, `REG_TMR_CTRL), 32'h0);
		repeat (2) @(posedge clk);
		end_test("count load");

		$display("tests run %0d, failed %0d, failing checks %0d",
			tests_run, tests_failed, total_fail);
		if (tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+hw
hw/periph_pkg.sv
hw/bus_decode.sv
hw/mod_gpio.sv
hw/mod_timer.sv
hw/read_return.sv
hw/periph_top.sv
sim/periph_assertions.sv
sim/tb_periph.sv

/* Makefile */
# Verilator build and run for the peripheral subsystem.
TOP = tb_periph

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
